/* rtl/trig_loop_pkg.sv */
`default_nettype none

package trig_loop_pkg;

    // array sizes
    localparam int n_beams = 8;
    localparam int beam_idx_w = 3;
    localparam int thresh_w = 18;
    localparam int scaler_w = 32;
    localparam int delta_w = 16;
    localparam int bus_adr_w = 12;

    // loop constants
    localparam logic [thresh_w-1:0] start_thresh = 18'd4500;
    localparam int count_window = 256;
    localparam int count_margin = 2;
    localparam int win_w = $clog2(count_window);
    localparam logic [win_w-1:0] win_last = win_w'(count_window - 1);
    // beam index counts down from here, msb set means the sweep is done
    localparam logic [beam_idx_w:0] beam_last = (beam_idx_w + 1)'(n_beams - 1);

    // counter bus map, beam n sits at base + 4n
    localparam logic [bus_adr_w-1:0] ctl_adr = 12'h000;
    localparam logic [bus_adr_w-1:0] thresh_base = 12'h400;
    localparam logic [bus_adr_w-1:0] ce_base = 12'h800;

    // host registers
    // ctl:    [0] enable, [5:4] mode request
    // man:    [17:0] data, [26:24] index, [28] write, [29] update
    // status: [1:0] mode, [4] reset complete, [8] manual ack
    localparam logic [2:0] reg_ctl = 3'd0;
    localparam logic [2:0] reg_rate = 3'd1;
    localparam logic [2:0] reg_delta = 3'd2;
    localparam logic [2:0] reg_man = 3'd3;
    localparam logic [2:0] reg_status = 3'd4;
    localparam logic [2:0] reg_thresh_rd = 3'd5;
    localparam logic [2:0] reg_scal_sel = 3'd6;
    localparam logic [2:0] reg_scal_rd = 3'd7;

    typedef enum logic [1:0] {
        mode_reset = 2'd0,
        mode_run = 2'd1,
        mode_stop = 2'd2,
        mode_pause = 2'd3
    } loop_mode_e;

    typedef enum logic [3:0] {
        st_reset_start, st_resetting, st_reset_complete, st_idle,
        st_count_start, st_count_wait, st_count_read, st_thresh_calc,
        st_count_beam_inc, st_thresh_write, st_thresh_write_wait, st_thresh_apply,
        st_thresh_beam_inc, st_thresh_update, st_stop_prep
    } servo_state_e;

    typedef struct packed {
        logic cyc;
        logic we;
        logic [bus_adr_w-1:0] adr;
        logic [scaler_w-1:0] dat;
    } loop_bus_req_t;

    typedef struct packed {
        logic ack;
        logic [scaler_w-1:0] dat;
    } loop_bus_rsp_t;

    typedef struct packed {
        logic enable;
        loop_mode_e mode_req;
        logic [scaler_w-1:0] target_rate;
        logic [delta_w-1:0] target_delta;
        logic [beam_idx_w-1:0] man_idx;
        logic [thresh_w-1:0] man_dat;
        logic man_wr;
        logic man_upd;
    } loop_cfg_t;

    typedef struct packed {
        loop_mode_e mode;
        logic reset_complete;
        logic man_ack;
        logic [thresh_w-1:0] thresh_rd;
        logic [scaler_w-1:0] scal_rd;
    } loop_status_t;

endpackage

`default_nettype wire

/* rtl/loop_config_regs.sv */
`default_nettype none

module loop_config_regs (
    input wire wb_clk_i,
    input wire rst_i,
    input wire reg_stb_i,
    input wire reg_we_i,
    input wire [2:0] reg_adr_i,
    input wire [31:0] reg_dat_i,
    output logic [31:0] reg_dat_o,
    output trig_loop_pkg::loop_cfg_t cfg_o,
    input wire trig_loop_pkg::loop_status_t status_i,
    output logic [trig_loop_pkg::beam_idx_w-1:0] scal_sel_o
);

    wire wr = reg_stb_i && reg_we_i;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            cfg_o <= '0;
            scal_sel_o <= '0;
        end else begin
            // pending manual requests drop on ack
            if (status_i.man_ack) begin
                cfg_o.man_wr <= 1'b0;
                cfg_o.man_upd <= 1'b0;
            end
            if (wr) begin
                case (reg_adr_i)
                    trig_loop_pkg::reg_ctl: begin
                        cfg_o.enable <= reg_dat_i[0];
                        cfg_o.mode_req <= trig_loop_pkg::loop_mode_e'(reg_dat_i[5:4]);
                    end
                    trig_loop_pkg::reg_rate: cfg_o.target_rate <= reg_dat_i;
                    trig_loop_pkg::reg_delta: cfg_o.target_delta <= reg_dat_i[15:0];
                    trig_loop_pkg::reg_man: begin
                        cfg_o.man_dat <= reg_dat_i[17:0];
                        cfg_o.man_idx <= reg_dat_i[26:24];
                        // a new request wins over an ack in the same cycle
                        if (reg_dat_i[28])
                            cfg_o.man_wr <= 1'b1;
                        if (reg_dat_i[29])
                            cfg_o.man_upd <= 1'b1;
                    end
                    trig_loop_pkg::reg_scal_sel: scal_sel_o <= reg_dat_i[2:0];
                    default: ;
                endcase
            end
        end
    end

    // readback, no wait states
    always_comb begin
        case (reg_adr_i)
            trig_loop_pkg::reg_ctl:
                reg_dat_o = {26'b0, cfg_o.mode_req, 3'b0, cfg_o.enable};
            trig_loop_pkg::reg_rate: reg_dat_o = cfg_o.target_rate;
            trig_loop_pkg::reg_delta: reg_dat_o = 32'(cfg_o.target_delta);
            trig_loop_pkg::reg_man:
                reg_dat_o = {2'b0, cfg_o.man_upd, cfg_o.man_wr, 1'b0, cfg_o.man_idx,
                             6'b0, cfg_o.man_dat};
            trig_loop_pkg::reg_status:
                reg_dat_o = {23'b0, status_i.man_ack, 3'b0, status_i.reset_complete,
                             2'b0, status_i.mode};
            trig_loop_pkg::reg_thresh_rd: reg_dat_o = 32'(status_i.thresh_rd);
            trig_loop_pkg::reg_scal_sel: reg_dat_o = 32'(scal_sel_o);
            default: reg_dat_o = status_i.scal_rd;
        endcase
    end

    // in stop mode the servo only acks a request that is really pending
    a_ack_pending: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (status_i.man_ack && status_i.mode == trig_loop_pkg::mode_stop)
            |-> (cfg_o.man_wr || cfg_o.man_upd));

endmodule

`default_nettype wire

/* rtl/threshold_servo.sv */
`default_nettype none

module threshold_servo (
    input wire wb_clk_i,
    input wire rst_i,
    input wire trig_loop_pkg::loop_cfg_t cfg_i,
    input wire [trig_loop_pkg::beam_idx_w-1:0] scal_sel_i,
    output trig_loop_pkg::loop_status_t status_o,
    output trig_loop_pkg::loop_bus_req_t bus_o,
    input wire trig_loop_pkg::loop_bus_rsp_t bus_i,
    input wire count_done_i
);

    trig_loop_pkg::servo_state_e state;
    trig_loop_pkg::loop_mode_e loop_mode;
    logic reset_done;

    // counts down, msb flags the end of a sweep
    logic [trig_loop_pkg::beam_idx_w:0] beam_idx;
    wire beam_done = beam_idx[trig_loop_pkg::beam_idx_w];

    logic [trig_loop_pkg::bus_adr_w-1:0] adr;
    logic [trig_loop_pkg::scaler_w-1:0] dat;
    logic [trig_loop_pkg::thresh_w-1:0] thresh_tmp;
    logic [trig_loop_pkg::thresh_w-1:0] thresh_regs [trig_loop_pkg::n_beams];
    logic [trig_loop_pkg::scaler_w-1:0] scaler_mem [trig_loop_pkg::n_beams];
    logic [trig_loop_pkg::scaler_w:0] rate_lim;

    // stop mode works on the manual index, everything else sweeps
    wire [trig_loop_pkg::beam_idx_w-1:0] cur_beam = (loop_mode == trig_loop_pkg::mode_stop) ?
        cfg_i.man_idx : beam_idx[trig_loop_pkg::beam_idx_w-1:0];

    wire cyc = state inside {trig_loop_pkg::st_count_start, trig_loop_pkg::st_count_read,
                             trig_loop_pkg::st_thresh_write, trig_loop_pkg::st_thresh_apply,
                             trig_loop_pkg::st_thresh_update};
    wire we = cyc && state != trig_loop_pkg::st_count_read;
    wire upd_cmd = (state == trig_loop_pkg::st_thresh_beam_inc && beam_done) ||
                   (state == trig_loop_pkg::st_stop_prep && cfg_i.man_upd);

    assign rate_lim = {1'b0, cfg_i.target_rate} + trig_loop_pkg::count_margin;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state <= trig_loop_pkg::st_reset_start;
            loop_mode <= trig_loop_pkg::mode_reset;
            reset_done <= 1'b0;
            beam_idx <= trig_loop_pkg::beam_last;
        end else begin
            // mode only moves in idle
            if (state == trig_loop_pkg::st_idle)
                loop_mode <= cfg_i.mode_req;

            if (state == trig_loop_pkg::st_reset_complete)
                reset_done <= 1'b1;
            else if (cfg_i.mode_req == trig_loop_pkg::mode_reset)
                reset_done <= 1'b0;

            case (state)
                trig_loop_pkg::st_reset_start:
                    if (cfg_i.enable)
                        state <= trig_loop_pkg::st_resetting;
                trig_loop_pkg::st_resetting:
                    if (beam_done)
                        state <= trig_loop_pkg::st_thresh_beam_inc;
                trig_loop_pkg::st_reset_complete:
                    if (cfg_i.mode_req != trig_loop_pkg::mode_reset)
                        state <= trig_loop_pkg::st_idle;
                trig_loop_pkg::st_idle: begin
                    // request must have settled into loop_mode first
                    if (cfg_i.mode_req == loop_mode) begin
                        if (loop_mode == trig_loop_pkg::mode_reset)
                            state <= trig_loop_pkg::st_reset_start;
                        else if (loop_mode != trig_loop_pkg::mode_stop)
                            state <= trig_loop_pkg::st_count_start;
                        else if (cfg_i.man_wr || cfg_i.man_upd)
                            state <= trig_loop_pkg::st_stop_prep;
                    end
                end
                trig_loop_pkg::st_count_start:
                    if (bus_i.ack)
                        state <= trig_loop_pkg::st_count_wait;
                trig_loop_pkg::st_count_wait:
                    if (count_done_i)
                        state <= trig_loop_pkg::st_count_read;
                trig_loop_pkg::st_count_read:
                    if (bus_i.ack)
                        state <= trig_loop_pkg::st_thresh_calc;
                trig_loop_pkg::st_thresh_calc: state <= trig_loop_pkg::st_count_beam_inc;
                trig_loop_pkg::st_count_beam_inc: begin
                    if (!beam_done)
                        state <= trig_loop_pkg::st_count_read;
                    else if (loop_mode == trig_loop_pkg::mode_pause)
                        state <= trig_loop_pkg::st_idle;
                    else
                        state <= trig_loop_pkg::st_thresh_beam_inc;
                end
                trig_loop_pkg::st_thresh_write:
                    if (bus_i.ack)
                        state <= trig_loop_pkg::st_thresh_write_wait;
                trig_loop_pkg::st_thresh_write_wait: state <= trig_loop_pkg::st_thresh_apply;
                trig_loop_pkg::st_thresh_apply: begin
                    if (bus_i.ack && loop_mode == trig_loop_pkg::mode_stop)
                        state <= trig_loop_pkg::st_idle;
                    else if (bus_i.ack)
                        state <= trig_loop_pkg::st_thresh_beam_inc;
                end
                trig_loop_pkg::st_thresh_beam_inc:
                    state <= beam_done ? trig_loop_pkg::st_thresh_update
                                       : trig_loop_pkg::st_thresh_write;
                trig_loop_pkg::st_thresh_update: begin
                    if (bus_i.ack && loop_mode == trig_loop_pkg::mode_reset)
                        state <= trig_loop_pkg::st_reset_complete;
                    else if (bus_i.ack)
                        state <= trig_loop_pkg::st_idle;
                end
                // the pass through thresh_beam_inc gives the stored value a cycle to land
                trig_loop_pkg::st_stop_prep:
                    state <= cfg_i.man_upd ? trig_loop_pkg::st_thresh_update
                                           : trig_loop_pkg::st_thresh_beam_inc;
                default: state <= trig_loop_pkg::st_reset_start;
            endcase

            if (state inside {trig_loop_pkg::st_reset_start, trig_loop_pkg::st_idle} || beam_done)
                beam_idx <= trig_loop_pkg::beam_last;
            else if (state == trig_loop_pkg::st_thresh_calc ||
                     state == trig_loop_pkg::st_resetting ||
                     (state == trig_loop_pkg::st_thresh_apply && bus_i.ack))
                beam_idx <= beam_idx - 1'b1;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        // address for the next bus cycle
        if (state == trig_loop_pkg::st_idle || upd_cmd)
            adr <= trig_loop_pkg::ctl_adr;
        else if (state == trig_loop_pkg::st_count_wait ||
                 state == trig_loop_pkg::st_count_beam_inc ||
                 state == trig_loop_pkg::st_thresh_beam_inc)
            adr <= trig_loop_pkg::thresh_base + {cur_beam, 2'b00};
        else if (state == trig_loop_pkg::st_thresh_write_wait)
            adr <= trig_loop_pkg::ce_base + {cur_beam, 2'b00};

        // start and mark both write 1, update writes 2
        if (state == trig_loop_pkg::st_idle || state == trig_loop_pkg::st_thresh_write_wait)
            dat <= 32'd1;
        else if (upd_cmd)
            dat <= 32'd2;
        else if (state == trig_loop_pkg::st_thresh_beam_inc)
            dat <= 32'(thresh_regs[cur_beam]);

        // working threshold, adjusted on the scaler ack
        if (state == trig_loop_pkg::st_reset_start)
            thresh_tmp <= trig_loop_pkg::start_thresh;
        else if (state == trig_loop_pkg::st_count_read && !bus_i.ack)
            thresh_tmp <= thresh_regs[cur_beam];
        else if (state == trig_loop_pkg::st_count_read && {1'b0, bus_i.dat} < rate_lim)
            thresh_tmp <= thresh_tmp + cfg_i.target_delta;
        else if (state == trig_loop_pkg::st_count_read && {1'b0, bus_i.dat} > rate_lim)
            thresh_tmp <= thresh_tmp - cfg_i.target_delta;
        else if (state == trig_loop_pkg::st_idle && cfg_i.man_wr)
            thresh_tmp <= cfg_i.man_dat;

        if ((state == trig_loop_pkg::st_thresh_calc && loop_mode == trig_loop_pkg::mode_run) ||
            (state == trig_loop_pkg::st_resetting && !beam_done) ||
            (state == trig_loop_pkg::st_stop_prep && cfg_i.man_wr))
            thresh_regs[cur_beam] <= thresh_tmp;

        if (state == trig_loop_pkg::st_count_read && bus_i.ack)
            scaler_mem[cur_beam] <= bus_i.dat;
    end

    always_comb begin
        bus_o.cyc = cyc;
        bus_o.we = we;
        bus_o.adr = adr;
        bus_o.dat = dat;
        status_o.mode = loop_mode;
        status_o.reset_complete = reset_done;
        // outside stop mode manual requests are acked and dropped
        status_o.man_ack = (state == trig_loop_pkg::st_stop_prep) ||
                           (loop_mode != trig_loop_pkg::mode_stop);
        status_o.thresh_rd = thresh_regs[cfg_i.man_idx];
        status_o.scal_rd = scaler_mem[scal_sel_i];
    end

    // a new cycle never starts on top of the previous ack
    a_cyc_rise: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $rose(bus_o.cyc) |-> !bus_i.ack);
    a_req_stable: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (bus_o.cyc && !bus_i.ack) |=> $stable(bus_o));

endmodule

`default_nettype wire

/* rtl/beam_trigger_counter.sv */
`default_nettype none

module beam_trigger_counter (
    input wire wb_clk_i,
    input wire rst_i,
    input wire trig_loop_pkg::loop_bus_req_t bus_i,
    output trig_loop_pkg::loop_bus_rsp_t bus_o,
    output logic count_done_o,
    input wire [trig_loop_pkg::n_beams-1:0][trig_loop_pkg::thresh_w-1:0] beam_power_i,
    output logic [trig_loop_pkg::n_beams-1:0] beam_trig_o
);

    logic ack_q;
    logic running;
    logic [trig_loop_pkg::win_w-1:0] win_cnt;
    logic [trig_loop_pkg::n_beams-1:0] marks;
    logic [trig_loop_pkg::thresh_w-1:0] staged [trig_loop_pkg::n_beams];
    logic [trig_loop_pkg::thresh_w-1:0] active [trig_loop_pkg::n_beams];
    logic [trig_loop_pkg::scaler_w-1:0] hits [trig_loop_pkg::n_beams];
    logic [trig_loop_pkg::scaler_w-1:0] scalers [trig_loop_pkg::n_beams];
    logic [trig_loop_pkg::scaler_w-1:0] rd_dat;

    // one ack per cycle, taken the cycle after cyc shows up
    wire accept = bus_i.cyc && !ack_q;
    wire [trig_loop_pkg::beam_idx_w-1:0] sel = bus_i.adr[trig_loop_pkg::beam_idx_w+1:2];
    wire win_end = running && win_cnt == trig_loop_pkg::win_last;

    // decode on the bits above the beam field
    wire is_ctl = bus_i.adr == trig_loop_pkg::ctl_adr;
    wire is_thresh = bus_i.adr[11:5] == trig_loop_pkg::thresh_base[11:5];
    wire is_ce = bus_i.adr[11:5] == trig_loop_pkg::ce_base[11:5];
    wire start_wr = accept && bus_i.we && is_ctl && bus_i.dat == 32'd1;
    wire update_wr = accept && bus_i.we && is_ctl && bus_i.dat == 32'd2;

    always_comb begin
        for (int b = 0; b < trig_loop_pkg::n_beams; b++)
            beam_trig_o[b] = beam_power_i[b] > active[b];
        bus_o.ack = ack_q;
        bus_o.dat = rd_dat;
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            running <= 1'b0;
            win_cnt <= '0;
            count_done_o <= 1'b0;
            marks <= '0;
            for (int b = 0; b < trig_loop_pkg::n_beams; b++)
                active[b] <= trig_loop_pkg::start_thresh;
        end else begin
            ack_q <= accept;
            count_done_o <= win_end;

            // window timer
            if (start_wr) begin
                running <= 1'b1;
                win_cnt <= '0;
            end else if (running) begin
                win_cnt <= win_cnt + 1'b1;
                if (win_end)
                    running <= 1'b0;
            end

            if (accept && bus_i.we && is_ce)
                marks[sel] <= bus_i.dat[0];

            // update moves every marked beam at once
            if (update_wr) begin
                for (int b = 0; b < trig_loop_pkg::n_beams; b++)
                    if (marks[b])
                        active[b] <= staged[b];
                marks <= '0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (accept && bus_i.we && is_thresh)
            staged[sel] <= bus_i.dat[trig_loop_pkg::thresh_w-1:0];
        // read data lines up with the ack
        if (accept)
            rd_dat <= scalers[sel];

        for (int b = 0; b < trig_loop_pkg::n_beams; b++) begin
            if (start_wr)
                hits[b] <= '0;
            else if (running)
                hits[b] <= hits[b] + beam_trig_o[b];
            // last window cycle still counts
            if (win_end)
                scalers[b] <= hits[b] + beam_trig_o[b];
        end
    end

    a_no_restart: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        start_wr |-> !running);

endmodule

`default_nettype wire

/* rtl/trig_loop_top.sv */
`default_nettype none

module trig_loop_top (
    input wire wb_clk_i,
    input wire rst_i,
    input wire reg_stb_i,
    input wire reg_we_i,
    input wire [2:0] reg_adr_i,
    input wire [31:0] reg_dat_i,
    output logic [31:0] reg_dat_o,
    input wire [trig_loop_pkg::n_beams-1:0][trig_loop_pkg::thresh_w-1:0] beam_power_i,
    output logic [trig_loop_pkg::n_beams-1:0] beam_trig_o
);

    trig_loop_pkg::loop_cfg_t cfg;
    trig_loop_pkg::loop_status_t status;
    trig_loop_pkg::loop_bus_req_t bus_req;
    trig_loop_pkg::loop_bus_rsp_t bus_rsp;
    logic [trig_loop_pkg::beam_idx_w-1:0] scal_sel;
    logic count_done;

    // host side configuration and readback
    loop_config_regs u_regs (
        .wb_clk_i(wb_clk_i),
        .rst_i(rst_i),
        .reg_stb_i(reg_stb_i),
        .reg_we_i(reg_we_i),
        .reg_adr_i(reg_adr_i),
        .reg_dat_i(reg_dat_i),
        .reg_dat_o(reg_dat_o),
        .cfg_o(cfg),
        .status_i(status),
        .scal_sel_o(scal_sel)
    );

    // bus master running the rate loop
    threshold_servo u_servo (
        .wb_clk_i(wb_clk_i),
        .rst_i(rst_i),
        .cfg_i(cfg),
        .scal_sel_i(scal_sel),
        .status_o(status),
        .bus_o(bus_req),
        .bus_i(bus_rsp),
        .count_done_i(count_done)
    );

    beam_trigger_counter u_counter (
        .wb_clk_i(wb_clk_i),
        .rst_i(rst_i),
        .bus_i(bus_req),
        .bus_o(bus_rsp),
        .count_done_o(count_done),
        .beam_power_i(beam_power_i),
        .beam_trig_o(beam_trig_o)
    );

endmodule

`default_nettype wire

/* tests/trig_loop_tb.sv */
`default_nettype none

module trig_loop_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic wb_clk;
    logic rst;
    logic reg_stb;
    logic reg_we;
    logic [2:0] reg_adr;
    logic [31:0] reg_dat;
    logic [31:0] reg_rd;
    logic [trig_loop_pkg::n_beams-1:0][trig_loop_pkg::thresh_w-1:0] beam_power;
    logic [trig_loop_pkg::n_beams-1:0] beam_trig;

    int errors;
    int timeouts;
    int checks;
    int fd;
    int n;
    logic abort;
    string line;

    trig_loop_top uut (
        .wb_clk_i(wb_clk),
        .rst_i(rst),
        .reg_stb_i(reg_stb),
        .reg_we_i(reg_we),
        .reg_adr_i(reg_adr),
        .reg_dat_i(reg_dat),
        .reg_dat_o(reg_rd),
        .beam_power_i(beam_power),
        .beam_trig_o(beam_trig)
    );

    // 8 ns period
    always #4 wb_clk = ~wb_clk;

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    // one host write, strobe high for a single edge
    task automatic host_write(input logic [2:0] adr, input logic [31:0] dat);
        @(posedge wb_clk);
        #1;
        reg_stb = 1'b1;
        reg_we = 1'b1;
        reg_adr = adr;
        reg_dat = dat;
        @(posedge wb_clk);
        #1;
        reg_stb = 1'b0;
        reg_we = 1'b0;
    endtask

    // read data is combinational, sampled mid cycle
    task automatic host_read(input logic [2:0] adr, output logic [31:0] dat);
        @(posedge wb_clk);
        #1;
        reg_adr = adr;
        #2;
        dat = reg_rd;
    endtask

    task automatic set_power(input logic [2:0] beam, input logic [17:0] val);
        @(posedge wb_clk);
        #1;
        beam_power[beam] = val;
    endtask

    // poll a register field, give up after 2000 cycles
    task automatic wait_field(input logic [2:0] adr, input logic [31:0] mask,
                              input logic [31:0] val, input string test);
        logic [31:0] got;
        int cycles;
        logic hit;
        cycles = 0;
        hit = 1'b0;
        while (!hit && cycles < 2000) begin
            host_read(adr, got);
            hit = (got & mask) === val;
            cycles++;
        end
        if (!hit) begin
            timeouts++;
            abort = 1'b1;
            $display("timeout in %s: register %0d did not reach %h within %0d cycles",
                     test, adr, val, cycles);
        end
    endtask

    // sweep all beams, beams in hit_mask expect hit_val and the rest miss_val
    task automatic check_beams(input logic scaler, input string test,
                               input logic [31:0] hit_mask, input logic [31:0] hit_val,
                               input logic [31:0] miss_val);
        logic [31:0] got;
        for (int b = 0; b < trig_loop_pkg::n_beams; b++) begin
            if (scaler) begin
                host_write(trig_loop_pkg::reg_scal_sel, 32'(b));
                host_read(trig_loop_pkg::reg_scal_rd, got);
            end else begin
                // index only, no request bits
                host_write(trig_loop_pkg::reg_man, 32'(b) << 24);
                host_read(trig_loop_pkg::reg_thresh_rd, got);
            end
            check_value($sformatf("%s_b%0d", test, b), hit_mask[b] ? hit_val : miss_val, got);
        end
    endtask

    task automatic run_command(input string text);
        string op;
        string test;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] got;
        int fields;
        fields = $sscanf(text, "%s %h %h %h %s", op, a, b, c, test);
        if (fields != 5) begin
            errors++;
            abort = 1'b1;
            $display("stimulus line could not be parsed: %s", text);
        end else begin
            case (op)
                "wr": host_write(a[2:0], b);
                "rd": begin
                    host_read(a[2:0], got);
                    check_value(test, c, got & b);
                end
                "wt": wait_field(a[2:0], b, c, test);
                "pw": set_power(a[2:0], b[17:0]);
                "id": repeat (a) @(posedge wb_clk);
                "trg": begin
                    @(posedge wb_clk);
                    #3;
                    check_value(test, a, 32'(beam_trig));
                end
                "thr": begin
                    host_write(trig_loop_pkg::reg_man, {5'b0, a[2:0], 24'b0});
                    host_read(trig_loop_pkg::reg_thresh_rd, got);
                    check_value(test, b, got);
                end
                "thrs": check_beams(1'b0, test, a, b, c);
                "scls": check_beams(1'b1, test, a, b, c);
                default: begin
                    errors++;
                    abort = 1'b1;
                    $display("unknown command %s in test %s", op, test);
                end
            endcase
        end
    endtask

    initial begin
        wb_clk = 1'b0;
        rst = 1'b1;
        reg_stb = 1'b0;
        reg_we = 1'b0;
        reg_adr = '0;
        reg_dat = '0;
        beam_power = '0;
        errors = 0;
        timeouts = 0;
        checks = 0;
        abort = 1'b0;
        repeat (5) @(posedge wb_clk);
        #1;
        rst = 1'b0;

        fd = $fopen("tests/trig_loop_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/trig_loop_tests.txt");
        end else begin
            // one command per line, lines starting with # are skipped
            while (!abort && !$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#")
                    run_command(line);
            end
            $fclose(fd);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/trig_loop_pkg.sv
rtl/loop_config_regs.sv
rtl/threshold_servo.sv
rtl/beam_trigger_counter.sv
rtl/trig_loop_top.sv
tests/trig_loop_tb.sv

/* tests/trig_loop_tests.txt */
# columns: command arg_a arg_b arg_c test_name, numbers in hex
# wr adr dat | rd,wt adr mask val | pw beam power | id cycles | trg bits | thr beam val | thrs,scls hit_mask hit_val miss_val
pw 0 1388 0 pwr_b0
pw 1 fa0 0 pwr_b1
pw 2 1195 0 pwr_b2
pw 3 1194 0 pwr_b3
pw 4 116c 0 pwr_b4
pw 5 11bc 0 pwr_b5
pw 6 2328 0 pwr_b6
pw 7 64 0 pwr_b7
wr 0 1 0 bringup_enable
wt 4 10 10 bringup_done
thrs ff 1194 0 bringup_thresh
trg 65 0 0 bringup_trig
wr 0 31 0 pause_req
wt 4 3 3 pause_mode
id 4 0 0 pause_start
wr 0 21 0 pause_to_stop
wt 4 3 2 pause_stop
scls 65 100 0 pause_scal
thrs ff 1194 0 pause_thresh
wr 1 64 0 run_rate
wr 2 32 0 run_delta
wr 0 11 0 run_req
wt 4 3 1 run_mode
id 4 0 0 run_start
wr 0 21 0 run_to_stop
wt 4 3 2 run_stop
thrs 65 1162 11c6 run_thresh
pw 2 116c 0 run_pwr_b2
pw 4 11a8 0 run_pwr_b4
trg 65 0 0 run_trig
wr 3 13001388 0 man_write
wt 3 10000000 0 man_write_ack
id a 0 0 man_write_settle
thr 3 1388 0 man_thresh
wr 3 23001388 0 man_update
wt 3 20000000 0 man_update_ack
id 8 0 0 man_update_settle
pw 3 1389 0 man_pwr_above
trg 6d 0 0 man_trig_above
pw 3 1388 0 man_pwr_equal
trg 65 0 0 man_trig_equal
pw 3 1387 0 man_pwr_below
trg 65 0 0 man_trig_below
wr 0 11 0 drop_run_req
wt 4 3 1 drop_run_mode
wr 3 13001000 0 drop_write
id 2 0 0 drop_settle
rd 3 30000000 0 drop_no_pending
wr 0 21 0 drop_to_stop
wt 4 3 2 drop_stop
thr 3 13ba 0 drop_thresh
wr 0 1 0 rerun_reset_req
id 4 0 0 rerun_settle
wt 4 10 10 rerun_done
thrs ff 1194 0 rerun_thresh
trg 79 0 0 rerun_trig
